// ==== project.f ====
+incdir+bench
verilog/cpuIsaPkg.sv
verilog/cpuCtrlPkg.sv
verilog/controlSequencer.sv
verilog/registerFile.sv
verilog/aluUnit.sv
verilog/memoryUnit.sv
verilog/loadStoreCpu.sv
bench/loadStoreCpuTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the load/store CPU testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f project.f \
   --top-module loadStoreCpuTb \
   -o loadStoreCpuTb

# Exit status is nonzero when the testbench stops with $fatal
./obj_dir/loadStoreCpuTb

// ==== bench/cpuRefModel.svh ====
// Instruction-level reference model predicting one retire record per instruction
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

logic [dataW-1:0] modelRegs [regCount];
logic [dataW-1:0] modelMem [memDepth];

function automatic void resetModel();
   for (int i = 0; i < regCount; i++)
      modelRegs[i] = '0;
endfunction

// Runs one instruction on the model state and returns its retire record
function automatic retireT executeInstr(instrT instr);
   retireT           rec;
   logic [dataW-1:0] base;
   logic [dataW-1:0] immVal;
   logic [dataW-1:0] result;
   memAddrT          addr;
   rec = '0;
   // Base operand, R0 counts as zero
   base   = (instr.r.rb == '0) ? '0 : modelRegs[instr.r.rb];
   immVal = dataW'($signed(instr.i.imm));
   addr   = memAddrT'(base + immVal);
   case (instr.r.opcode)
      opAdd:   result = base + modelRegs[instr.r.rc];
      opSub:   result = base - modelRegs[instr.r.rc];
      opAnd:   result = base & modelRegs[instr.r.rc];
      opOr:    result = base | modelRegs[instr.r.rc];
      opLdi:   result = base + immVal;
      opLd:    result = modelMem[addr];
      default: result = modelRegs[instr.r.ra];
   endcase
   rec.addr = addr;
   rec.data = result;
   if (instr.r.opcode == opSt) begin
      rec.isStore   = 1'b1;
      modelMem[addr] = result;
   end else begin
      rec.dest = instr.r.ra;
      modelRegs[instr.r.ra] = result;
   end
   return rec;
endfunction

`endif

// ==== bench/loadStoreCpuTb.sv ====
// Testbench running random programs on the load/store CPU against a reference model
`timescale 1ns/1ps

module loadStoreCpuTb import cpuIsaPkg::*; ();

   localparam int progCount = 5;
   localparam int instrCount = 40;
   localparam int codeLen = instrCount + 1;
   localparam int resetCycles = 8;
   localparam int maxInstrCycles = 8;
   localparam int clkPeriodNs = 10;
   // Reset, full memory load and worst-case execution per program, doubled
   localparam int watchdogNs = progCount * clkPeriodNs * 2 *
      (resetCycles + memDepth + codeLen * maxInstrCycles + 20);

   logic             Clock;
   logic             arstN;
   logic             start;
   logic             loadEn;
   memAddrT          loadAddr;
   logic [dataW-1:0] loadData;
   logic             busy;
   logic             halted;
   retireT           retire;
   logic             retireValid;

   logic [dataW-1:0] progImage [memDepth];
   retireT           expectedQ [$];

   `include "cpuRefModel.svh"

   loadStoreCpu u_dut (
      .Clock       (Clock),
      .arstN       (arstN),
      .start       (start),
      .loadEn      (loadEn),
      .loadAddr    (loadAddr),
      .loadData    (loadData),
      .busy        (busy),
      .halted      (halted),
      .retire      (retire),
      .retireValid (retireValid)
   );

   always #5 Clock = ~Clock;

   task automatic failRun(string reason);
      $display("%s", reason);
      $display("Some tests failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic reportMismatch(string field, logic [dataW-1:0] expectedVal,
                                 logic [dataW-1:0] actualVal);
      failRun($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", field, expectedVal,
                        actualVal));
   endtask

   task automatic applyReset();
      @(posedge Clock);
      arstN <= 1'b0;
      repeat (resetCycles) @(posedge Clock);
      arstN <= 1'b1;
      @(negedge Clock);
      assert (!busy && !halted && !retireValid)
         else failRun("Status outputs are not cleared after reset");
   endtask

   // Nothing may run or retire before start
   task automatic expectIdle();
      @(negedge Clock);
      assert (!busy && !halted && !retireValid)
         else failRun("CPU is active or retiring before start");
   endtask

   task automatic buildProgram();
      instrT            instr;
      opcodeT           op;
      logic [dataW-1:0] base;
      memAddrT          target;
      expectedQ.delete();
      resetModel();
      for (int a = codeLen; a < memDepth; a++) begin
         progImage[a] = $urandom();
         modelMem[a]  = progImage[a];
      end
      for (int n = 0; n < instrCount; n++) begin
         op    = opcodeT'(5'($urandom() % 7));
         instr = instrT'($urandom());
         instr.r.opcode = op;
         if (op == opLd || op == opSt) begin
            // Keep ld/st in the data area, often in a small window so loads revisit stores
            base = (instr.i.rb == '0) ? '0 : modelRegs[instr.i.rb];
            if ($urandom() % 2 == 0)
               target = memAddrT'(codeLen + $urandom() % 8);
            else
               target = memAddrT'(codeLen + $urandom() % (memDepth - codeLen));
            instr.i.imm[memAddrW-1:0] = target - base[memAddrW-1:0];
         end
         progImage[n] = instr;
         modelMem[n]  = instr;
         expectedQ.push_back(executeInstr(instr));
      end
      instr = instrT'($urandom());
      instr.r.opcode = opHalt;
      progImage[instrCount] = instr;
      modelMem[instrCount]  = instr;
   endtask

   task automatic loadProgram();
      for (int a = 0; a < memDepth; a++) begin
         @(posedge Clock);
         loadEn   <= 1'b1;
         loadAddr <= memAddrT'(a);
         loadData <= progImage[a];
         expectIdle();
      end
      @(posedge Clock);
      loadEn <= 1'b0;
   endtask

   task automatic compareRetire();
      retireT expected;
      assert (expectedQ.size() > 0)
         else failRun("Retire record seen after every instruction had retired");
      expected = expectedQ.pop_front();
      assert (retire.isStore == expected.isStore)
         else reportMismatch("retire.isStore", dataW'(expected.isStore), dataW'(retire.isStore));
      // Stores carry an address, register writes a destination
      if (expected.isStore) begin
         assert (retire.addr == expected.addr)
            else reportMismatch("retire.addr", dataW'(expected.addr), dataW'(retire.addr));
      end else begin
         assert (retire.dest == expected.dest)
            else reportMismatch("retire.dest", dataW'(expected.dest), dataW'(retire.dest));
      end
      assert (retire.data == expected.data)
         else reportMismatch("retire.data", expected.data, retire.data);
   endtask

   task automatic runProgram();
      logic done;
      @(posedge Clock);
      start <= 1'b1;
      @(posedge Clock);
      start <= 1'b0;
      done = 1'b0;
      while (!done) begin
         @(negedge Clock);
         if (retireValid)
            compareRetire();
         done = halted && !busy;
      end
      assert (expectedQ.size() == 0)
         else failRun($sformatf("CPU halted with %0d instructions not retired",
                                expectedQ.size()));
      repeat (4) begin
         @(negedge Clock);
         assert (halted && !busy && !retireValid)
            else failRun("CPU left the halted state or retired after halt");
      end
   endtask

   initial begin
      #(watchdogNs);
      failRun("Watchdog expired before all programs finished");
   end

   initial begin
      Clock    = 1'b0;
      arstN    = 1'b0;
      start    = 1'b0;
      loadEn   = 1'b0;
      loadAddr = '0;
      loadData = '0;
      void'($urandom(32'h6298));
      for (int p = 0; p < progCount; p++) begin
         applyReset();
         buildProgram();
         loadProgram();
         runProgram();
      end
      $display("All tests passed");
      $finish;
   end

endmodule

// ==== verilog/loadStoreCpu.sv ====
// Load/store CPU top with PC, IR, bus multiplexer and retire record
`timescale 1ns/1ps

module loadStoreCpu import cpuIsaPkg::*, cpuCtrlPkg::*; (
   input  logic             Clock,
   input  logic             arstN,
   input  logic             start,
   input  logic             loadEn,
   input  memAddrT          loadAddr,
   input  logic [dataW-1:0] loadData,
   output logic             busy,
   output logic             halted,
   output retireT           retire,
   output logic             retireValid
);

   ctrlWordT         ctrl;
   instrT            ir;
   logic [dataW-1:0] pc;
   logic [dataW-1:0] bus;
   logic [dataW-1:0] immExt;
   logic [dataW-1:0] regOut;
   logic [dataW-1:0] mdrOut;
   logic [dataW-1:0] rzOut;
   regIdxT           regSel;
   memAddrT          marOut;
   logic             retireStore;

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
      end else if (ctrl.pcIn) begin
         pc <= bus;
      end else if (ctrl.incPc) begin
         pc <= pc + 1'b1;
      end
   end

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         ir <= '0;
      end else if (ctrl.irIn) begin
         ir <= bus;
      end
   end

   assign immExt = {{(dataW-immW){ir.i.imm[immW-1]}}, ir.i.imm};

   // Single bus, one source per cycle
   always_comb begin
      case (ctrl.busSrc)
         busPc:   bus = pc;
         busMdr:  bus = mdrOut;
         busReg:  bus = regOut;
         busRz:   bus = rzOut;
         busImm:  bus = immExt;
         default: bus = '0;
      endcase
   end

   controlSequencer u_seq (
      .Clock       (Clock),
      .arstN       (arstN),
      .start       (start),
      .ir          (ir),
      .ctrl        (ctrl),
      .busy        (busy),
      .halted      (halted),
      .retireValid (retireValid),
      .retireStore (retireStore)
   );

   registerFile u_regs (
      .Clock  (Clock),
      .arstN  (arstN),
      .ctrl   (ctrl),
      .ir     (ir),
      .busIn  (bus),
      .regOut (regOut),
      .regSel (regSel)
   );

   aluUnit u_alu (
      .Clock (Clock),
      .arstN (arstN),
      .ctrl  (ctrl),
      .busIn (bus),
      .rzOut (rzOut)
   );

   memoryUnit u_mem (
      .Clock    (Clock),
      .arstN    (arstN),
      .ctrl     (ctrl),
      .busIn    (bus),
      .loadEn   (loadEn),
      .loadAddr (loadAddr),
      .loadData (loadData),
      .mdrOut   (mdrOut),
      .marOut   (marOut)
   );

   // Bus carries the written value in the retiring phase
   assign retire.isStore = retireStore;
   assign retire.dest    = regSel;
   assign retire.addr    = marOut;
   assign retire.data    = bus;

endmodule

// ==== verilog/memoryUnit.sv ====
// MAR, MDR and word memory with an external program-load port
`timescale 1ns/1ps

module memoryUnit import cpuIsaPkg::*, cpuCtrlPkg::*; (
   input  logic             Clock,
   input  logic             arstN,
   input  ctrlWordT         ctrl,
   input  logic [dataW-1:0] busIn,
   input  logic             loadEn,
   input  memAddrT          loadAddr,
   input  logic [dataW-1:0] loadData,
   output logic [dataW-1:0] mdrOut,
   output memAddrT          marOut
);

   logic [dataW-1:0] mem [memDepth];
   memAddrT          mar;
   logic [dataW-1:0] mdr;

   // Only the low bits of the bus address memory
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         mar <= '0;
      end else if (ctrl.marIn) begin
         mar <= busIn[memAddrW-1:0];
      end
   end

   // Memory read lands in the MDR one cycle after mdrRead
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         mdr <= '0;
      end else if (ctrl.mdrRead) begin
         mdr <= mem[mar];
      end else if (ctrl.mdrBusIn) begin
         mdr <= busIn;
      end
   end

   always_ff @(posedge Clock) begin
      if (loadEn)
         mem[loadAddr] <= loadData;
      else if (ctrl.memWrite)
         mem[mar] <= mdr;
   end

   assign mdrOut = mdr;
   assign marOut = mar;

   // Program loading happens only while the CPU is stopped
   assert property (@(posedge Clock) disable iff (!arstN)
      !(loadEn && ctrl.memWrite));

endmodule

// ==== verilog/aluUnit.sv ====
// Combinational ALU between the RY operand and RZ result registers
`timescale 1ns/1ps

module aluUnit import cpuIsaPkg::*, cpuCtrlPkg::*; (
   input  logic             Clock,
   input  logic             arstN,
   input  ctrlWordT         ctrl,
   input  logic [dataW-1:0] busIn,
   output logic [dataW-1:0] rzOut
);

   logic [dataW-1:0] ry;
   logic [dataW-1:0] rz;
   logic [dataW-1:0] aluResult;

   // First operand is RY, second comes straight from the bus
   always_comb begin
      case (ctrl.aluOp)
         aluAdd:  aluResult = ry + busIn;
         aluSub:  aluResult = ry - busIn;
         aluAnd:  aluResult = ry & busIn;
         aluOr:   aluResult = ry | busIn;
         default: aluResult = ry + busIn;
      endcase
   end

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         ry <= '0;
      end else if (ctrl.ryIn) begin
         ry <= busIn;
      end
   end

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         rz <= '0;
      end else if (ctrl.rzIn) begin
         rz <= aluResult;
      end
   end

   assign rzOut = rz;

endmodule

// ==== verilog/registerFile.sv ====
// Register file of sixteen general registers with base-address zeroing
`timescale 1ns/1ps

module registerFile import cpuIsaPkg::*, cpuCtrlPkg::*; (
   input  logic             Clock,
   input  logic             arstN,
   input  ctrlWordT         ctrl,
   input  instrT            ir,
   input  logic [dataW-1:0] busIn,
   output logic [dataW-1:0] regOut,
   output regIdxT           regSel
);

   logic [dataW-1:0] regs [regCount];

   // Select encoder, ra/rb/rc by gra/grb/grc
   always_comb begin
      if (ctrl.gra)
         regSel = ir.r.ra;
      else if (ctrl.grb)
         regSel = ir.r.rb;
      else if (ctrl.grc)
         regSel = ir.r.rc;
      else
         regSel = '0;
   end

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < regCount; i++)
            regs[i] <= '0;
      end else if (ctrl.regIn) begin
         regs[regSel] <= busIn;
      end
   end

   // R0 as a base address reads as zero
   always_comb begin
      if (ctrl.baOut && regSel == '0)
         regOut = '0;
      else
         regOut = regs[regSel];
   end

   // Sequencer selects at most one register field at a time
   assert property (@(posedge Clock) disable iff (!arstN)
      $onehot0({ctrl.gra, ctrl.grb, ctrl.grc}));

endmodule

// ==== verilog/controlSequencer.sv ====
// Phase sequencer decoding the IR into one control word per cycle
`timescale 1ns/1ps

module controlSequencer import cpuIsaPkg::*, cpuCtrlPkg::*; (
   input  logic     Clock,
   input  logic     arstN,
   input  logic     start,
   input  instrT    ir,
   output ctrlWordT ctrl,
   output logic     busy,
   output logic     halted,
   output logic     retireValid,
   output logic     retireStore
);

   phaseT  phase;
   phaseT  nextPhase;
   opcodeT op;
   logic   isAlu;
   logic   isLd;
   logic   isLdi;
   logic   isSt;
   logic   isHalt;
   logic   shortOp;
   aluOpT  decodedAluOp;

   // Opcode decode, anything unknown is treated as halt
   assign op      = ir.r.opcode;
   assign isAlu   = (op == opAdd) || (op == opSub) || (op == opAnd) || (op == opOr);
   assign isLd    = (op == opLd);
   assign isLdi   = (op == opLdi);
   assign isSt    = (op == opSt);
   assign isHalt  = !(isAlu || isLd || isLdi || isSt);
   assign shortOp = isAlu || isLdi;

   always_comb begin
      case (op)
         opSub:   decodedAluOp = aluSub;
         opAnd:   decodedAluOp = aluAnd;
         opOr:    decodedAluOp = aluOr;
         default: decodedAluOp = aluAdd;
      endcase
   end

   always_comb begin
      nextPhase = phase;
      case (phase)
         idle:    nextPhase = start ? T0 : idle;
         T0:      nextPhase = T1;
         T1:      nextPhase = T2;
         T2:      nextPhase = T3;
         T3:      nextPhase = isHalt ? idle : T4;
         T4:      nextPhase = T5;
         T5:      nextPhase = shortOp ? T0 : T6;
         T6:      nextPhase = T7;
         T7:      nextPhase = T0;
         default: nextPhase = idle;
      endcase
   end

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         phase  <= idle;
         halted <= 1'b0;
      end else begin
         phase <= nextPhase;
         if (phase == idle && start)
            halted <= 1'b0;
         else if (phase == T3 && isHalt)
            halted <= 1'b1;
      end
   end

   assign busy = (phase != idle);

   // Control word for the current phase
   always_comb begin
      ctrl = '0;
      ctrl.busSrc = busNone;
      ctrl.aluOp  = aluAdd;
      case (phase)
         T0: begin
            ctrl.busSrc = busPc;
            ctrl.marIn  = 1'b1;
            ctrl.incPc  = 1'b1;
         end
         T1: ctrl.mdrRead = 1'b1;
         T2: begin
            ctrl.busSrc = busMdr;
            ctrl.irIn   = 1'b1;
         end
         T3: begin
            if (!isHalt) begin
               // Base register, R0 reads as zero here
               ctrl.busSrc = busReg;
               ctrl.grb    = 1'b1;
               ctrl.baOut  = 1'b1;
               ctrl.ryIn   = 1'b1;
            end
         end
         T4: begin
            ctrl.rzIn = 1'b1;
            if (isAlu) begin
               ctrl.busSrc = busReg;
               ctrl.grc    = 1'b1;
               ctrl.aluOp  = decodedAluOp;
            end else begin
               ctrl.busSrc = busImm;
            end
         end
         T5: begin
            ctrl.busSrc = busRz;
            if (shortOp) begin
               ctrl.gra   = 1'b1;
               ctrl.regIn = 1'b1;
            end else begin
               ctrl.marIn = 1'b1;
            end
         end
         T6: begin
            if (isLd) begin
               ctrl.mdrRead = 1'b1;
            end else begin
               ctrl.busSrc   = busReg;
               ctrl.gra      = 1'b1;
               ctrl.mdrBusIn = 1'b1;
            end
         end
         T7: begin
            // Store data stays visible on the bus for the retire record
            ctrl.busSrc = busMdr;
            if (isLd) begin
               ctrl.gra   = 1'b1;
               ctrl.regIn = 1'b1;
            end else begin
               ctrl.memWrite = 1'b1;
            end
         end
         default: ;
      endcase
   end

   assign retireValid = (phase == T5 && shortOp) || (phase == T7);
   assign retireStore = (phase == T7) && isSt;

   // A cycle never both writes a register and memory
   assert property (@(posedge Clock) disable iff (!arstN)
      !(ctrl.regIn && ctrl.memWrite));

   // No retire while idle or once halted
   assert property (@(posedge Clock) disable iff (!arstN)
      retireValid |-> busy && !halted);

endmodule

// ==== verilog/cpuCtrlPkg.sv ====
// Control definitions shared by the sequencer and the datapath blocks
package cpuCtrlPkg;

   // Source that drives the internal bus
   typedef enum logic [2:0] {
      busNone = 3'd0,
      busPc   = 3'd1,
      busMdr  = 3'd2,
      busReg  = 3'd3,
      busRz   = 3'd4,
      busImm  = 3'd5
   } busSrcT;

   // Instruction phases, idle between runs
   typedef enum logic [3:0] {
      T0   = 4'd0,
      T1   = 4'd1,
      T2   = 4'd2,
      T3   = 4'd3,
      T4   = 4'd4,
      T5   = 4'd5,
      T6   = 4'd6,
      T7   = 4'd7,
      idle = 4'd8
   } phaseT;

   typedef enum logic [1:0] {
      aluAdd = 2'd0,
      aluSub = 2'd1,
      aluAnd = 2'd2,
      aluOr  = 2'd3
   } aluOpT;

   // One control word per cycle, all fields are single-cycle levels
   typedef struct packed {
      busSrcT busSrc;
      logic   pcIn;
      logic   incPc;
      logic   irIn;
      logic   marIn;
      logic   mdrRead;
      logic   mdrBusIn;
      logic   memWrite;
      logic   ryIn;
      logic   rzIn;
      logic   regIn;
      logic   gra;
      logic   grb;
      logic   grc;
      logic   baOut;
      aluOpT  aluOp;
   } ctrlWordT;

endpackage

// ==== verilog/cpuIsaPkg.sv ====
// Instruction set definitions: formats, opcodes, register and memory sizes
package cpuIsaPkg;

   // Data and bus width
   localparam int dataW = 32;

   localparam int regCount = 16;
   localparam int regIdxW = $clog2(regCount);

   localparam int memDepth = 256;
   localparam int memAddrW = $clog2(memDepth);

   localparam int immW = 19;

   typedef logic [regIdxW-1:0] regIdxT;
   typedef logic [memAddrW-1:0] memAddrT;

   // Codes outside this list execute as halt
   typedef enum logic [4:0] {
      opLd   = 5'd0,
      opLdi  = 5'd1,
      opSt   = 5'd2,
      opAdd  = 5'd3,
      opSub  = 5'd4,
      opAnd  = 5'd5,
      opOr   = 5'd6,
      opHalt = 5'd7
   } opcodeT;

   // Register format used by the ALU ops
   typedef struct packed {
      opcodeT      opcode;
      regIdxT      ra;
      regIdxT      rb;
      regIdxT      rc;
      logic [14:0] unused;
   } rFmtT;

   // Immediate format used by ld, ldi and st
   typedef struct packed {
      opcodeT                  opcode;
      regIdxT                  ra;
      regIdxT                  rb;
      logic signed [immW-1:0]  imm;
   } iFmtT;

   // One instruction word seen through both formats
   typedef union packed {
      rFmtT r;
      iFmtT i;
   } instrT;

   // Record emitted when an instruction completes
   typedef struct packed {
      logic             isStore;
      regIdxT           dest;
      memAddrT          addr;
      logic [dataW-1:0] data;
   } retireT;

endpackage
